/* source/peGeomPkg.sv */
/*
 * Geometry of the processing-element cluster.
 * Element width, channels per vector, kernel width and the
 * accumulator widths that follow from them.
 * Imported by the RTL blocks that size loops or counters.
 */
package peGeomPkg;

    // ============================================================
    // Array shape
    // ============================================================
    // Signed activation or weight element
    localparam int DATA_WIDTH   = 8;
    // Channels in one activation or weight vector
    localparam int BLOCK_DEPTH  = 4;
    // Weight vectors per kernel, one lane each
    localparam int KERNEL_WIDTH = 3;

    // ============================================================
    // Derived widths
    // ============================================================
    // Product width plus headroom for BLOCK_DEPTH terms
    localparam int DOT_WIDTH    = 2 * DATA_WIDTH + 2;
    // Sum of KERNEL_WIDTH dot products
    localparam int PSUM_WIDTH   = DOT_WIDTH + 2;
    // Position within a row, up to 64 activations
    localparam int IDX_WIDTH    = 6;

endpackage

/* source/peDataPkg.sv */
/*
 * Data types shared by the cluster blocks.
 * Vectors, nonzero flags, dot products and partial sums,
 * plus the per-kernel bundles of each.
 * Widths come from the geometry package.
 */
package peDataPkg;

    import peGeomPkg::*;

    // ============================================================
    // Single values
    // ============================================================
    typedef logic signed [DATA_WIDTH-1:0] elemT;
    // One vector of BLOCK_DEPTH channels, channel 0 in the low bits
    typedef elemT [BLOCK_DEPTH-1:0] vecT;
    // Nonzero flag per channel
    typedef logic [BLOCK_DEPTH-1:0] flagT;
    // Lane result
    typedef logic signed [DOT_WIDTH-1:0] dotT;
    // Output partial sum
    typedef logic signed [PSUM_WIDTH-1:0] psumT;
    // Position in a row
    typedef logic [IDX_WIDTH-1:0] idxT;

    // ============================================================
    // Per-kernel bundles
    // ============================================================
    // Index k is kernel tap k
    typedef vecT [KERNEL_WIDTH-1:0] weiSetT;
    typedef flagT [KERNEL_WIDTH-1:0] weiFlagSetT;
    typedef dotT [KERNEL_WIDTH-1:0] dotSetT;

endpackage

/* source/macIf.sv */
/*
 * Control to lane-array bundle.
 * Carries the weight load strobe and data, the registered
 * activation with its flags and row end, and the start pulse.
 * Driven through the control modport and read through array.
 */
`timescale 1ns/1ps

interface macIf
    import peDataPkg::*;
();

    // Weight load, written on the edge where loadWei is high
    logic       loadWei;
    weiSetT     weiData;
    weiFlagSetT weiFlag;

    // One cycle pulse once the activation is registered
    logic       start;
    // Held until the next activation is accepted
    vecT        actData;
    flagT       actFlag;
    logic       rowEnd;

    modport control (
        output loadWei, weiData, weiFlag,
        output start, actData, actFlag, rowEnd
    );

    modport array (
        input loadWei, weiData, weiFlag,
        input start, actData, actFlag, rowEnd
    );

endinterface

/* source/peControl.sv */
/*
 * Decode stage of the cluster.
 * Runs the weight and activation get handshakes, registers each
 * accepted activation and fires the start pulse to the lanes.
 * Waits for dotValid before taking the next activation.
 */
`timescale 1ns/1ps

module peControl
    import peDataPkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // Weight source
    input  logic       weiRdy,
    output logic       weiGet,
    input  weiSetT     weight,
    input  weiFlagSetT weightFlag,
    // Activation source
    input  logic       actRdy,
    output logic       actGet,
    input  vecT        act,
    input  flagT       actFlag,
    input  logic       lastRow,
    input  logic       lastBlock,
    // From the lane array
    input  logic       dotValid,
    macIf.control      mac
);

    typedef enum logic [1:0] {
        LoadWei,
        WaitAct,
        Compute
    } stateT;

    stateT state;
    stateT stateNext;
    // lastBlock of the activation in flight
    logic  lastBlk;

    // ============================================================
    // Handshake FSM
    // ============================================================
    // Get pulses while the source holds ready
    assign weiGet = (state == LoadWei) && weiRdy;
    assign actGet = (state == WaitAct) && actRdy;

    always_comb begin
        stateNext = state;
        case (state)
            LoadWei: if (weiRdy) stateNext = WaitAct;
            WaitAct: if (actRdy) stateNext = Compute;
            // Back to weights at the end of a block
            Compute: if (dotValid) stateNext = lastBlk ? LoadWei : WaitAct;
            default: stateNext = LoadWei;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LoadWei;
        end else begin
            state <= stateNext;
        end
    end

    // ============================================================
    // Weight load
    // ============================================================
    // Array writes its weight registers on the get edge
    assign mac.loadWei = weiGet;
    assign mac.weiData = weight;
    assign mac.weiFlag = weightFlag;

    // ============================================================
    // Activation register and start
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mac.start  <= 1'b0;
            mac.rowEnd <= 1'b0;
            lastBlk    <= 1'b0;
        end else begin
            // Start lands in the cycle after the get
            mac.start <= actGet;
            if (actGet) begin
                mac.rowEnd <= lastRow;
                lastBlk    <= lastBlock;
            end
        end
    end

    // Data and flags only
    always_ff @(posedge clk) begin
        if (actGet) begin
            mac.actData <= act;
            mac.actFlag <= actFlag;
        end
    end

endmodule

/* source/sparseMac.sv */
/*
 * One sparse multiply-accumulate lane.
 * On start it keeps only channels where both flags are set and
 * then spends one cycle per such channel, lowest first.
 * done pulses 1 + P cycles after start, with dot valid then.
 */
`timescale 1ns/1ps

module sparseMac
    import peGeomPkg::*;
    import peDataPkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  vecT  actData,
    input  flagT actFlag,
    input  vecT  weiData,
    input  flagT weiFlag,
    output logic done,
    output dotT  dot
);

    // Channels still to consume
    flagT mask;
    logic busy;
    dotT  acc;
    dotT  prod;

    // Product of the lowest matched channel
    always_comb begin
        prod = '0;
        // Walk down so the lowest set bit wins
        for (int ch = BLOCK_DEPTH - 1; ch >= 0; ch--) begin
            if (mask[ch]) begin
                prod = dotT'($signed(actData[ch])) * dotT'($signed(weiData[ch]));
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask <= '0;
            busy <= 1'b0;
        end else if (start) begin
            mask <= actFlag & weiFlag;
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end else begin
            // Drop the channel just consumed
            mask <= mask & (mask - 1'b1);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
        end else if (busy && (mask != '0)) begin
            acc <= acc + prod;
        end
    end

    // One cycle after the mask runs empty
    assign done = busy && (mask == '0);
    assign dot  = acc;

endmodule

/* source/macArray.sv */
/*
 * Execute stage of the cluster.
 * Holds the weight set and three sparse lanes. Lane results are
 * latched as each lane finishes, and dotValid pulses the cycle
 * after the slowest lane, with rowEnd carried alongside.
 */
`timescale 1ns/1ps

module macArray
    import peGeomPkg::*;
    import peDataPkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    macIf.array    mac,
    output logic   dotValid,
    output dotSetT dots,
    output logic   rowEnd
);

    weiSetT                  weiReg;
    weiFlagSetT              weiFlagReg;
    logic [KERNEL_WIDTH-1:0] laneDone;
    logic [KERNEL_WIDTH-1:0] doneSeen;
    dotSetT                  laneDot;
    // Set by start until all lanes report
    logic                    armed;
    logic                    allDone;

    // ============================================================
    // Weight registers
    // ============================================================
    always_ff @(posedge clk) begin
        if (mac.loadWei) begin
            weiReg     <= mac.weiData;
            weiFlagReg <= mac.weiFlag;
        end
    end

    // ============================================================
    // Lanes, one per kernel tap
    // ============================================================
    sparseMac lane0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mac.start),
        .actData (mac.actData),
        .actFlag (mac.actFlag),
        .weiData (weiReg[0]),
        .weiFlag (weiFlagReg[0]),
        .done    (laneDone[0]),
        .dot     (laneDot[0])
    );

    sparseMac lane1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mac.start),
        .actData (mac.actData),
        .actFlag (mac.actFlag),
        .weiData (weiReg[1]),
        .weiFlag (weiFlagReg[1]),
        .done    (laneDone[1]),
        .dot     (laneDot[1])
    );

    sparseMac lane2 (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mac.start),
        .actData (mac.actData),
        .actFlag (mac.actFlag),
        .weiData (weiReg[2]),
        .weiFlag (weiFlagReg[2]),
        .done    (laneDone[2]),
        .dot     (laneDot[2])
    );

    // ============================================================
    // Completion tracking
    // ============================================================
    // Last lane may finish this cycle
    assign allDone = armed && (&(doneSeen | laneDone));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed    <= 1'b0;
            doneSeen <= '0;
            dotValid <= 1'b0;
            rowEnd   <= 1'b0;
        end else begin
            dotValid <= allDone;
            if (mac.start) begin
                armed    <= 1'b1;
                doneSeen <= '0;
            end else if (allDone) begin
                armed    <= 1'b0;
                doneSeen <= '0;
                rowEnd   <= mac.rowEnd;
            end else begin
                doneSeen <= doneSeen | laneDone;
            end
        end
    end

    // Each lane result held from its own done
    always_ff @(posedge clk) begin
        for (int k = 0; k < KERNEL_WIDTH; k++) begin
            if (laneDone[k]) dots[k] <= laneDot[k];
        end
    end

endmodule

/* source/psumLine.sv */
/*
 * Result stage of the cluster.
 * Builds the 1-D row convolution from the three lane dots.
 * Two running partials hold outputs one and two positions back.
 * psumValid follows dotValid by one cycle, no back-pressure.
 */
`timescale 1ns/1ps

module psumLine
    import peGeomPkg::*;
    import peDataPkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   dotValid,
    input  dotSetT dots,
    input  logic   rowEnd,
    output logic   psumValid,
    output idxT    psumIndex,
    output psumT   psum
);

    // Activation position in the current row
    idxT  cnt;
    // Output one position back
    psumT partNew;
    // Output two positions back
    psumT partOld;
    logic emit;

    // First full output once KERNEL_WIDTH activations are in
    assign emit = dotValid && (cnt >= idxT'(KERNEL_WIDTH - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt       <= '0;
            partNew   <= '0;
            partOld   <= '0;
            psumValid <= 1'b0;
        end else begin
            psumValid <= emit;
            if (dotValid) begin
                if (rowEnd) begin
                    // Fresh row starts at position 0
                    cnt     <= '0;
                    partNew <= '0;
                    partOld <= '0;
                end else begin
                    cnt     <= cnt + 1'b1;
                    partOld <= partNew + psumT'(dots[1]);
                    partNew <= psumT'(dots[0]);
                end
            end
        end
    end

    // Output payload
    always_ff @(posedge clk) begin
        if (emit) begin
            psum      <= partOld + psumT'(dots[2]);
            psumIndex <= cnt - idxT'(KERNEL_WIDTH - 1);
        end
    end

endmodule

/* source/peCluster.sv */
/*
 * Top level of the processing-element cluster.
 * Plain ports for weight and activation ready/get exchanges and
 * the partial-sum output. Connects decode, execute and result.
 */
`timescale 1ns/1ps

module peCluster
    import peDataPkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // Weight exchange
    input  logic       weiRdy,
    output logic       weiGet,
    input  weiSetT     weight,
    input  weiFlagSetT weightFlag,
    // Activation exchange
    input  logic       actRdy,
    output logic       actGet,
    input  vecT        act,
    input  flagT       actFlag,
    input  logic       lastRow,
    input  logic       lastBlock,
    // Partial sums
    output logic       psumValid,
    output idxT        psumIndex,
    output psumT       psum
);

    logic   dotValid;
    dotSetT dots;
    logic   rowEnd;

    macIf mac0 ();

    peControl ctrl0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .weiRdy     (weiRdy),
        .weiGet     (weiGet),
        .weight     (weight),
        .weightFlag (weightFlag),
        .actRdy     (actRdy),
        .actGet     (actGet),
        .act        (act),
        .actFlag    (actFlag),
        .lastRow    (lastRow),
        .lastBlock  (lastBlock),
        .dotValid   (dotValid),
        .mac        (mac0.control)
    );

    macArray array0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .mac      (mac0.array),
        .dotValid (dotValid),
        .dots     (dots),
        .rowEnd   (rowEnd)
    );

    psumLine line0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .dotValid  (dotValid),
        .dots      (dots),
        .rowEnd    (rowEnd),
        .psumValid (psumValid),
        .psumIndex (psumIndex),
        .psum      (psum)
    );

endmodule

/* testbench/clockGen.sv */
/*
 * Clock and reset source for the cluster testbench.
 * 100 ns clock period, active-low reset held for 4 cycles.
 */
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rst_n
);

    // Half period of 50 ns
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Released on the 4th rising edge
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* testbench/peClusterTb.sv */
/*
 * Testbench for the processing-element cluster.
 * Offers weight sets and activation rows over the ready/get
 * exchanges with LFSR data, models the row convolution and
 * checks each partial sum and get pulse with immediate assertions.
 * One line per test, then a closing count line and the verdict.
 */
`timescale 1ns/1ps

module peClusterTb
    import peGeomPkg::*;
    import peDataPkg::*;
();

    logic       clk;
    logic       rst_n;
    logic       weiRdy;
    logic       weiGet;
    weiSetT     weight;
    weiFlagSetT weightFlag;
    logic       actRdy;
    logic       actGet;
    vecT        act;
    flagT       actFlag;
    logic       lastRow;
    logic       lastBlock;
    logic       psumValid;
    idxT        psumIndex;
    psumT       psum;

    // Model state
    logic [31:0] lfsrState = 32'hc964_16d3;
    weiSetT      modelWei;
    weiFlagSetT  modelWeiFlag;
    vecT         rowAct [$];
    flagT        rowFlag [$];
    int          expIndex [$];
    int          expValue [$];

    // Counters
    string testName    = "reset";
    int    errorCount  = 0;
    int    checkCount  = 0;
    int    testErrors  = 0;
    int    testsRun    = 0;
    int    testsFailed = 0;
    int    weiOffered  = 0;
    int    actOffered  = 0;
    int    weiGetSeen  = 0;
    int    actGetSeen  = 0;
    int    outputsSeen = 0;
    logic  prevWeiGet  = 1'b0;
    logic  prevActGet  = 1'b0;
    int    cycleCount  = 0;
    // 43 activations over all tests
    int    cycleLimit  = 43 * (BLOCK_DEPTH + 6) + 200;

    clockGen clock0 (.clk(clk), .rst_n(rst_n));

    peCluster dut0 (.*);

    // ============================================================
    // Random data and reference model
    // ============================================================
    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value     = {value[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return value;
    endfunction

    // Only channels flagged on both sides count
    function automatic int dotModel(input vecT a, input flagT af, input vecT w, input flagT wf);
        int sum;
        sum = 0;
        for (int c = 0; c < BLOCK_DEPTH; c++) begin
            if (af[c] && wf[c]) begin
                sum += int'(a[c]) * int'(w[c]);
            end
        end
        return sum;
    endfunction

    task automatic compareValue(input string what, input int expected, input int actual);
        checkCount++;
        assert (actual == expected) else begin
            $display("Fail %s %s: expected %0d, actual %0d", testName, what, expected, actual);
            errorCount++;
        end
    endtask

    task automatic confirm(input bit condition, input string message);
        checkCount++;
        assert (condition) else begin
            $display("%s: %s", testName, message);
            errorCount++;
        end
    endtask

    // ============================================================
    // Output and handshake monitor
    // ============================================================
    always @(negedge clk) begin
        if (rst_n) begin
            confirm(!(prevWeiGet && weiGet), "weiGet stayed high for two cycles");
            confirm(!(prevActGet && actGet), "actGet stayed high for two cycles");
            prevWeiGet = weiGet;
            prevActGet = actGet;
            if (weiGet) weiGetSeen++;
            if (actGet) actGetSeen++;
            if (psumValid) begin
                outputsSeen++;
                if (expIndex.size() == 0) begin
                    confirm(1'b0, "psumValid pulsed with no output outstanding");
                end else begin
                    compareValue("psumIndex", expIndex.pop_front(), int'(psumIndex));
                    compareValue("psum", expValue.pop_front(), int'(psum));
                end
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Some tests failed");
            $finish;
        end
    end

    // ============================================================
    // Stimulus tasks
    // ============================================================
    // Random weight set, dense or random flags
    task automatic loadWeights(input bit sparse);
        weiSetT     w;
        weiFlagSetT f;
        for (int k = 0; k < KERNEL_WIDTH; k++) begin
            w[k] = vecT'(takeBits(32));
            f[k] = sparse ? flagT'(takeBits(BLOCK_DEPTH)) : '1;
        end
        @(posedge clk);
        weiRdy     <= 1'b1;
        weight     <= w;
        weightFlag <= f;
        weiOffered++;
        @(negedge clk);
        while (!weiGet) @(negedge clk);
        // Taken on this edge
        @(posedge clk);
        weiRdy       <= 1'b0;
        modelWei     = w;
        modelWeiFlag = f;
    endtask

    task automatic offerActivation(input vecT a, input flagT f, input bit endRow,
                                   input bit endBlk);
        @(posedge clk);
        actRdy    <= 1'b1;
        act       <= a;
        actFlag   <= f;
        lastRow   <= endRow;
        lastBlock <= endBlk;
        actOffered++;
    endtask

    // Wait for the get, then queue any output this activation completes
    task automatic completeActivation();
        int pos;
        int value;
        @(negedge clk);
        while (!actGet) @(negedge clk);
        rowAct.push_back(act);
        rowFlag.push_back(actFlag);
        pos = rowAct.size() - 1;
        if (pos >= KERNEL_WIDTH - 1) begin
            value = 0;
            for (int k = 0; k < KERNEL_WIDTH; k++) begin
                value += dotModel(rowAct[pos - KERNEL_WIDTH + 1 + k],
                                  rowFlag[pos - KERNEL_WIDTH + 1 + k],
                                  modelWei[k], modelWeiFlag[k]);
            end
            expIndex.push_back(pos - KERNEL_WIDTH + 1);
            expValue.push_back(value);
        end
        if (lastRow) begin
            rowAct.delete();
            rowFlag.delete();
        end
        @(posedge clk);
        actRdy <= 1'b0;
    endtask

    // zeroPos marks one activation with all flags clear
    task automatic sendRow(input int len, input bit sparse, input int zeroPos,
                           input bit endBlk);
        flagT f;
        for (int i = 0; i < len; i++) begin
            f = sparse ? flagT'(takeBits(BLOCK_DEPTH)) : '1;
            if (i == zeroPos) f = '0;
            offerActivation(vecT'(takeBits(32)), f, i == len - 1, endBlk && (i == len - 1));
            completeActivation();
        end
    endtask

    task automatic drainOutputs();
        while (expIndex.size() != 0) @(negedge clk);
        // Room for a stray pulse
        repeat (2) @(negedge clk);
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = errorCount;
    endtask

    task automatic endTest();
        drainOutputs();
        compareValue("weiGet pulses", weiOffered, weiGetSeen);
        compareValue("actGet pulses", actOffered, actGetSeen);
        testsRun++;
        if (errorCount == testErrors) begin
            $display("Test %0d %s: ok", testsRun, testName);
        end else begin
            testsFailed++;
            $display("Test %0d %s: %0d errors", testsRun, testName, errorCount - testErrors);
        end
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        int mark;
        int holdCycles;
        weiRdy     = 1'b0;
        weight     = '0;
        weightFlag = '0;
        actRdy     = 1'b0;
        act        = '0;
        actFlag    = '0;
        lastRow    = 1'b0;
        lastBlock  = 1'b0;

        // Outputs quiet through reset and the first cycle after
        startTest("reset and get pulses");
        do begin
            @(negedge clk);
            compareValue("weiGet", 0, int'(weiGet));
            compareValue("actGet", 0, int'(actGet));
            compareValue("psumValid", 0, int'(psumValid));
        end while (!rst_n);
        loadWeights(1'b0);
        sendRow(3, 1'b0, -1, 1'b0);
        endTest();

        // 8 activations, 6 outputs, block ends here
        startTest("dense row");
        mark = outputsSeen;
        sendRow(8, 1'b0, -1, 1'b1);
        drainOutputs();
        compareValue("output count", 6, outputsSeen - mark);
        endTest();

        startTest("sparse flags");
        loadWeights(1'b1);
        sendRow(6, 1'b1, -1, 1'b0);
        sendRow(6, 1'b1, -1, 1'b0);
        endTest();

        startTest("zero-flag activation");
        sendRow(5, 1'b0, 2, 1'b0);
        endTest();

        // Too short for an output, then a fresh row from index 0
        startTest("row restart");
        mark = outputsSeen;
        sendRow(2, 1'b1, -1, 1'b0);
        sendRow(5, 1'b1, -1, 1'b0);
        drainOutputs();
        compareValue("output count", 3, outputsSeen - mark);
        endTest();

        // Next activation waits on actRdy until new weights are in
        startTest("block end and reload");
        sendRow(4, 1'b1, -1, 1'b1);
        offerActivation(vecT'(takeBits(32)), '1, 1'b0, 1'b0);
        holdCycles = 0;
        while ((expIndex.size() != 0) || (holdCycles < BLOCK_DEPTH + 6)) begin
            @(negedge clk);
            confirm(!actGet, "actGet rose before new weights were loaded");
            holdCycles++;
        end
        loadWeights(1'b1);
        completeActivation();
        sendRow(3, 1'b1, -1, 1'b0);
        endTest();

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* src.f */
source/peGeomPkg.sv
source/peDataPkg.sv
source/macIf.sv
source/peControl.sv
source/sparseMac.sv
source/macArray.sv
source/psumLine.sv
source/peCluster.sv
testbench/clockGen.sv
testbench/peClusterTb.sv

/* Makefile */
# Verilator build, run, lint and clean for the PE cluster testbench

VERILATOR ?= verilator
TOP       ?= peClusterTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only --timing -Wall --timescale 1ns/1ps
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
